//--- rtl/mag_compass_pkg.sv
package mag_compass_pkg;

    ////////////////////////////////////////////////////////////
    // widths that carry a meaning
    ////////////////////////////////////////////////////////////

    // sensor register address
    typedef logic [7:0] reg_addr_t;

    // one byte read from or written to the sensor
    typedef logic [7:0] reg_data_t;

    // signed axis value, two bytes little endian on the sensor
    typedef logic signed [15:0] sample_t;

    // byte position inside one sample, 0 to 5
    typedef logic [2:0] byte_idx_t;

    // destination of an assembled sample
    typedef enum logic [1:0] {
        phase_cal_set,
        phase_cal_reset,
        phase_run
    } meas_phase_t;

    ////////////////////////////////////////////////////////////
    // sensor register map
    ////////////////////////////////////////////////////////////

    // x low, x high, y low, y high, z low, z high
    localparam reg_addr_t REG_DATA_BASE = 8'h00;
    // bit 0 set once a measurement is done
    localparam reg_addr_t REG_STATUS    = 8'h06;
    localparam reg_addr_t REG_CTRL      = 8'h07;

    // control register commands
    localparam reg_data_t CMD_REFILL  = 8'h80;
    localparam reg_data_t CMD_SET     = 8'h20;
    localparam reg_data_t CMD_RESET   = 8'h40;
    localparam reg_data_t CMD_MEASURE = 8'h01;

endpackage

//--- rtl/mag_sequencer.sv
module mag_sequencer #(
    parameter int unsigned STARTUP_CYCLES = 1_000_000,
    parameter int unsigned SETTLE_CYCLES  = 5_000_000,
    parameter int unsigned POLL_CYCLES    = 792_000
) (
    input  logic                         clk,
    input  logic                         reset_l,
    input  logic                         start,
    output logic                         cmd_valid,
    output logic                         cmd_write,
    output mag_compass_pkg::reg_addr_t   cmd_addr,
    output mag_compass_pkg::reg_data_t   cmd_wdata,
    input  logic                         cmd_done,
    input  mag_compass_pkg::reg_data_t   cmd_rdata,
    output logic                         byte_strobe,
    output mag_compass_pkg::byte_idx_t   byte_idx,
    output mag_compass_pkg::meas_phase_t phase
);
    import mag_compass_pkg::*;

    typedef enum logic [3:0] {
        st_startup,
        st_refill,
        st_settle,
        st_pulse,
        st_measure,
        st_poll_wait,
        st_status,
        st_read,
        st_idle
    } seq_state_t;

    seq_state_t  state;
    logic [31:0] wait_cnt;
    logic [31:0] wait_limit;
    logic        wait_over;
    byte_idx_t   byte_cnt;

    // length of the current wait step
    always_comb begin
        case (state)
            st_startup:   wait_limit = STARTUP_CYCLES;
            st_settle:    wait_limit = SETTLE_CYCLES;
            default:      wait_limit = POLL_CYCLES;
        endcase
    end

    assign wait_over = (wait_cnt == wait_limit - 32'd1);

    ////////////////////////////////////////////////////////////
    // step sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_l) begin
            state    <= st_startup;
            wait_cnt <= '0;
            byte_cnt <= '0;
            phase    <= phase_cal_set;
        end else begin
            case (state)
                st_startup, st_settle, st_poll_wait: begin
                    if (wait_over) begin
                        wait_cnt <= '0;
                        case (state)
                            st_startup: state <= st_refill;
                            st_settle:  state <= st_pulse;
                            default:    state <= st_status;
                        endcase
                    end else begin
                        wait_cnt <= wait_cnt + 32'd1;
                    end
                end
                st_refill:  if (cmd_done) state <= st_settle;
                st_pulse:   if (cmd_done) state <= st_measure;
                st_measure: if (cmd_done) state <= st_poll_wait;
                st_status: begin
                    // not ready yet, stay and poll again
                    if (cmd_done && cmd_rdata[0]) begin
                        byte_cnt <= '0;
                        state    <= st_read;
                    end
                end
                st_read: begin
                    if (cmd_done) begin
                        if (byte_cnt == byte_idx_t'(5)) begin
                            byte_cnt <= '0;
                            case (phase)
                                phase_cal_set: begin
                                    phase <= phase_cal_reset;
                                    state <= st_refill;
                                end
                                phase_cal_reset: begin
                                    phase <= phase_run;
                                    state <= st_idle;
                                end
                                default: state <= start ? st_measure : st_idle;
                            endcase
                        end else begin
                            byte_cnt <= byte_cnt + byte_idx_t'(1);
                        end
                    end
                end
                st_idle:  if (start) state <= st_measure;
                default:  state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // transaction decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr  = REG_CTRL;
        cmd_wdata = '0;
        case (state)
            st_refill: begin
                cmd_valid = 1'b1;
                cmd_write = 1'b1;
                cmd_wdata = CMD_REFILL;
            end
            st_pulse: begin
                cmd_valid = 1'b1;
                cmd_write = 1'b1;
                cmd_wdata = (phase == phase_cal_set) ? CMD_SET : CMD_RESET;
            end
            st_measure: begin
                cmd_valid = 1'b1;
                cmd_write = 1'b1;
                cmd_wdata = CMD_MEASURE;
            end
            st_status: begin
                cmd_valid = 1'b1;
                cmd_addr  = REG_STATUS;
            end
            st_read: begin
                cmd_valid = 1'b1;
                cmd_addr  = REG_DATA_BASE + reg_addr_t'(byte_cnt);
            end
            default: begin
            end
        endcase
    end

    // byte is in cmd_rdata during the done pulse
    assign byte_strobe = (state == st_read) && cmd_done;
    assign byte_idx    = byte_cnt;

endmodule

//--- rtl/mag_bus_port.sv
module mag_bus_port (
    input  logic                       clk,
    input  logic                       reset_l,
    input  logic                       cmd_valid,
    input  logic                       cmd_write,
    input  mag_compass_pkg::reg_addr_t cmd_addr,
    input  mag_compass_pkg::reg_data_t cmd_wdata,
    output logic                       cmd_done,
    output mag_compass_pkg::reg_data_t cmd_rdata,
    output logic                       txn_req,
    output logic                       txn_write,
    output mag_compass_pkg::reg_addr_t txn_addr,
    output mag_compass_pkg::reg_data_t txn_wdata,
    input  logic                       txn_ack,
    input  mag_compass_pkg::reg_data_t txn_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_ack_high,
        st_ack_low
    } port_state_t;

    port_state_t state;
    logic        accept;

    // cmd_valid is still high during the done pulse, so skip that cycle
    assign accept = (state == st_idle) && cmd_valid && !cmd_done;

    always_ff @(posedge clk) begin
        if (!reset_l) begin
            state    <= st_idle;
            txn_req  <= 1'b0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        txn_req <= 1'b1;
                        state   <= st_ack_high;
                    end
                end
                st_ack_high: begin
                    if (txn_ack) begin
                        txn_req <= 1'b0;
                        state   <= st_ack_low;
                    end
                end
                st_ack_low: begin
                    // handshake closed, agent has released ack
                    if (!txn_ack) begin
                        cmd_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request fields and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            txn_write <= cmd_write;
            txn_addr  <= cmd_addr;
            txn_wdata <= cmd_wdata;
        end
        if (state == st_ack_high && txn_ack) begin
            cmd_rdata <= txn_rdata;
        end
    end

endmodule

//--- rtl/mag_result.sv
module mag_result (
    input  logic                         clk,
    input  logic                         reset_l,
    input  logic                         byte_strobe,
    input  mag_compass_pkg::byte_idx_t   byte_idx,
    input  mag_compass_pkg::meas_phase_t phase,
    input  mag_compass_pkg::reg_data_t   cmd_rdata,
    output mag_compass_pkg::sample_t     x_data,
    output mag_compass_pkg::sample_t     y_data,
    output mag_compass_pkg::sample_t     z_data,
    output logic                         out_valid
);
    import mag_compass_pkg::*;

    // bytes 0 to 4 of the sample in flight
    reg_data_t byte_q [0:4];

    sample_t raw_x;
    sample_t raw_y;
    sample_t raw_z;

    // SET calibration sample
    sample_t cal_x;
    sample_t cal_y;
    sample_t cal_z;

    // mean of SET and RESET samples
    sample_t off_x;
    sample_t off_y;
    sample_t off_z;

    logic last_byte;

    // 17 bit sum, arithmetic shift by one, keep 16 bits
    function automatic sample_t mean2(input sample_t a, input sample_t b);
        logic [16:0] sum;
        sum = {a[15], a} + {b[15], b};
        return sample_t'(sum[16:1]);
    endfunction

    assign last_byte = byte_strobe && (byte_idx == byte_idx_t'(5));

    // z high comes straight from the bus in the last byte cycle
    assign raw_x = {byte_q[1], byte_q[0]};
    assign raw_y = {byte_q[3], byte_q[2]};
    assign raw_z = {cmd_rdata, byte_q[4]};

    ////////////////////////////////////////////////////////////
    // sample assembly and offset correction
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (byte_strobe && byte_idx < byte_idx_t'(5)) begin
            byte_q[byte_idx] <= cmd_rdata;
        end
        if (last_byte) begin
            case (phase)
                phase_cal_set: begin
                    cal_x <= raw_x;
                    cal_y <= raw_y;
                    cal_z <= raw_z;
                end
                phase_cal_reset: begin
                    off_x <= mean2(cal_x, raw_x);
                    off_y <= mean2(cal_y, raw_y);
                    off_z <= mean2(cal_z, raw_z);
                end
                default: begin
                    // wraps in 16 bits
                    x_data <= raw_x - off_x;
                    y_data <= raw_y - off_y;
                    z_data <= raw_z - off_z;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_l) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= last_byte && (phase == phase_run);
        end
    end

endmodule

//--- rtl/mag_compass_top.sv
module mag_compass_top #(
    parameter int unsigned STARTUP_CYCLES = 1_000_000,
    parameter int unsigned SETTLE_CYCLES  = 5_000_000,
    parameter int unsigned POLL_CYCLES    = 792_000
) (
    input  logic                       clk,
    input  logic                       reset_l,
    input  logic                       start,
    output logic                       txn_req,
    output logic                       txn_write,
    output mag_compass_pkg::reg_addr_t txn_addr,
    output mag_compass_pkg::reg_data_t txn_wdata,
    input  logic                       txn_ack,
    input  mag_compass_pkg::reg_data_t txn_rdata,
    output mag_compass_pkg::sample_t   x_data,
    output mag_compass_pkg::sample_t   y_data,
    output mag_compass_pkg::sample_t   z_data,
    output logic                       out_valid
);
    import mag_compass_pkg::*;

    ////////////////////////////////////////////////////////////
    // sequencer to bus port
    ////////////////////////////////////////////////////////////
    logic      cmd_valid;
    logic      cmd_write;
    reg_addr_t cmd_addr;
    reg_data_t cmd_wdata;
    logic      cmd_done;
    reg_data_t cmd_rdata;

    // sequencer to result stage
    logic        byte_strobe;
    byte_idx_t   byte_idx;
    meas_phase_t phase;

    mag_sequencer #(
        .STARTUP_CYCLES (STARTUP_CYCLES),
        .SETTLE_CYCLES  (SETTLE_CYCLES),
        .POLL_CYCLES    (POLL_CYCLES)
    ) u_sequencer (
        .clk         (clk),
        .reset_l     (reset_l),
        .start       (start),
        .cmd_valid   (cmd_valid),
        .cmd_write   (cmd_write),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .cmd_done    (cmd_done),
        .cmd_rdata   (cmd_rdata),
        .byte_strobe (byte_strobe),
        .byte_idx    (byte_idx),
        .phase       (phase)
    );

    mag_bus_port u_bus_port (
        .clk       (clk),
        .reset_l   (reset_l),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_done  (cmd_done),
        .cmd_rdata (cmd_rdata),
        .txn_req   (txn_req),
        .txn_write (txn_write),
        .txn_addr  (txn_addr),
        .txn_wdata (txn_wdata),
        .txn_ack   (txn_ack),
        .txn_rdata (txn_rdata)
    );

    mag_result u_result (
        .clk         (clk),
        .reset_l     (reset_l),
        .byte_strobe (byte_strobe),
        .byte_idx    (byte_idx),
        .phase       (phase),
        .cmd_rdata   (cmd_rdata),
        .x_data      (x_data),
        .y_data      (y_data),
        .z_data      (z_data),
        .out_valid   (out_valid)
    );

endmodule

//--- verification/mag_compass_assertions.sv
module mag_compass_assertions (
    input  logic                       clk,
    input  logic                       reset_l,
    input  logic                       txn_req,
    input  logic                       txn_write,
    input  mag_compass_pkg::reg_addr_t txn_addr,
    input  mag_compass_pkg::reg_data_t txn_wdata,
    input  logic                       txn_ack,
    input  logic                       out_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    ////////////////////////////////////////////////////////////
    // four-phase handshake
    ////////////////////////////////////////////////////////////

    // request fields frozen for the whole request
    property req_fields_stable;
        @(posedge clk) disable iff (!reset_l)
            txn_req && $past(txn_req) |-> $stable({txn_write, txn_addr, txn_wdata});
    endproperty

    // new request only once the agent has released ack
    property req_rise_ack_low;
        @(posedge clk) disable iff (!reset_l)
            $rose(txn_req) |-> !$past(txn_ack);
    endproperty

    // request dropped only in answer to ack
    property req_fall_on_ack;
        @(posedge clk) disable iff (!reset_l)
            $fell(txn_req) |-> $past(txn_ack);
    endproperty

    // outputs quiet while reset is held
    property quiet_in_reset;
        @(posedge clk) !reset_l |=> !txn_req && !out_valid;
    endproperty

    assert property (req_fields_stable) else begin
        fail_count++;
        $error("request fields changed while txn_req was high");
    end

    assert property (req_rise_ack_low) else begin
        fail_count++;
        $error("txn_req rose while txn_ack was still high");
    end

    assert property (req_fall_on_ack) else begin
        fail_count++;
        $error("txn_req dropped without txn_ack");
    end

    assert property (quiet_in_reset) else begin
        fail_count++;
        $error("txn_req or out_valid high during reset");
    end

endmodule

bind mag_compass_top mag_compass_assertions u_assertions (
    .clk       (clk),
    .reset_l   (reset_l),
    .txn_req   (txn_req),
    .txn_write (txn_write),
    .txn_addr  (txn_addr),
    .txn_wdata (txn_wdata),
    .txn_ack   (txn_ack),
    .out_valid (out_valid)
);

//--- verification/mag_compass_tb.sv
module mag_compass_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mag_compass_pkg::*;

    localparam int STARTUP_CYCLES = 20;
    localparam int SETTLE_CYCLES  = 8;
    localparam int POLL_CYCLES    = 4;
    localparam int NUM_ROWS       = 6;
    localparam int ROW_WIDTH      = 7;
    localparam int NUM_RUNS       = 4;

    logic      clk;
    logic      reset_l;
    logic      start;
    logic      txn_req;
    logic      txn_write;
    reg_addr_t txn_addr;
    reg_data_t txn_wdata;
    logic      txn_ack;
    reg_data_t txn_rdata;
    sample_t   x_data;
    sample_t   y_data;
    sample_t   z_data;
    logic      out_valid;

    // poll count and six bytes per row
    reg_data_t test_mem [0:NUM_ROWS*ROW_WIDTH-1];

    int   timeout_limit;
    int   out_count;
    int   write_count;
    int   measure_count;
    // agent position in the data file
    int   row_idx;
    int   status_reads;
    int   data_reads;
    logic ready_seen;

    mag_compass_top #(
        .STARTUP_CYCLES (STARTUP_CYCLES),
        .SETTLE_CYCLES  (SETTLE_CYCLES),
        .POLL_CYCLES    (POLL_CYCLES)
    ) UUT (
        .clk       (clk),
        .reset_l   (reset_l),
        .start     (start),
        .txn_req   (txn_req),
        .txn_write (txn_write),
        .txn_addr  (txn_addr),
        .txn_wdata (txn_wdata),
        .txn_ack   (txn_ack),
        .txn_rdata (txn_rdata),
        .x_data    (x_data),
        .y_data    (y_data),
        .z_data    (z_data),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    ////////////////////////////////////////////////////////////
    // reference values
    ////////////////////////////////////////////////////////////

    function automatic reg_data_t expected_ctrl_cmd(input int k);
        case (k)
            0, 3:    return CMD_REFILL;
            1:       return CMD_SET;
            4:       return CMD_RESET;
            default: return CMD_MEASURE;
        endcase
    endfunction

    // little endian axis word of one row
    function automatic int axis_raw(input int row, input int axis);
        logic [15:0] word;
        word = {test_mem[row * ROW_WIDTH + 2 + 2 * axis],
                test_mem[row * ROW_WIDTH + 1 + 2 * axis]};
        return int'($signed(word));
    endfunction

    // run value minus the floored mean of both calibration samples
    function automatic sample_t expected_axis(input int run, input int axis);
        int sum;
        int value;
        sum   = axis_raw(0, axis) + axis_raw(1, axis);
        value = axis_raw(2 + run, axis) - (sum >>> 1);
        return value[15:0];
    endfunction

    task automatic check_sample(input int run);
        assert (run < NUM_RUNS) else stop_with_error("more output samples than run rows");
        assert (x_data == expected_axis(run, 0)) else stop_with_error($sformatf(
            "Error at %0t ns: run %0d x_data %h, expected %h",
            $time, run, x_data, expected_axis(run, 0)));
        assert (y_data == expected_axis(run, 1)) else stop_with_error($sformatf(
            "Error at %0t ns: run %0d y_data %h, expected %h",
            $time, run, y_data, expected_axis(run, 1)));
        assert (z_data == expected_axis(run, 2)) else stop_with_error($sformatf(
            "Error at %0t ns: run %0d z_data %h, expected %h",
            $time, run, z_data, expected_axis(run, 2)));
    endtask

    ////////////////////////////////////////////////////////////
    // sensor and bus agent model
    ////////////////////////////////////////////////////////////

    task automatic check_ctrl_write(input reg_addr_t addr, input reg_data_t data);
        assert (addr == REG_CTRL) else stop_with_error($sformatf(
            "Error at %0t ns: write to register %h, expected %h", $time, addr, REG_CTRL));
        assert (data == expected_ctrl_cmd(write_count)) else stop_with_error($sformatf(
            "Error at %0t ns: control write %0d is %h, expected %h",
            $time, write_count, data, expected_ctrl_cmd(write_count)));
        if (data == CMD_MEASURE) begin
            measure_count++;
        end
        assert (measure_count <= 2 + NUM_RUNS)
            else stop_with_error("a measurement was started after start was dropped");
        write_count++;
    endtask

    task automatic serve_read(input reg_addr_t addr, output reg_data_t data);
        int polls;
        assert (row_idx < NUM_ROWS) else stop_with_error("bus read after the last sample");
        polls = int'(test_mem[row_idx * ROW_WIDTH]);
        if (addr == REG_STATUS) begin
            status_reads++;
            // other status bits set to catch a wrong bit test
            data = (status_reads > polls) ? 8'h01 : 8'hFE;
            if (status_reads > polls) begin
                ready_seen = 1'b1;
            end
        end else begin
            assert (addr < REG_DATA_BASE + 8'd6)
                else stop_with_error($sformatf("read of unknown register %h", addr));
            assert (ready_seen) else stop_with_error("data byte read before status reported done");
            assert (int'(addr - REG_DATA_BASE) == data_reads) else stop_with_error($sformatf(
                "Error at %0t ns: read of address %h, expected byte %0d",
                $time, addr, data_reads));
            if (data_reads == 0) begin
                assert (status_reads == polls + 1) else stop_with_error($sformatf(
                    "Error at %0t ns: %0d status reads in row %0d, expected %0d",
                    $time, status_reads, row_idx, polls + 1));
            end
            data = test_mem[row_idx * ROW_WIDTH + 1 + data_reads];
            data_reads++;
            if (data_reads == 6) begin
                row_idx++;
                data_reads   = 0;
                status_reads = 0;
                ready_seen   = 1'b0;
            end
        end
    endtask

    initial begin
        reg_data_t rdata;
        int        delay;
        void'($urandom(32'h8380));
        txn_ack       = 1'b0;
        txn_rdata     = '0;
        write_count   = 0;
        measure_count = 0;
        row_idx       = 0;
        status_reads  = 0;
        data_reads    = 0;
        ready_seen    = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (reset_l && txn_req) begin
                rdata = '0;
                if (txn_write) begin
                    check_ctrl_write(txn_addr, txn_wdata);
                end else begin
                    serve_read(txn_addr, rdata);
                end
                // slow agent, 0 to 5 cycles
                delay = int'($urandom % 6);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                txn_ack   = 1'b1;
                txn_rdata = rdata;
                do begin
                    @(posedge clk);
                    #1;
                end while (txn_req);
                txn_ack = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // output monitor, timeout and main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int since_reset;
        since_reset = 0;
        out_count   = 0;
        forever begin
            @(negedge clk);
            since_reset = reset_l ? since_reset + 1 : 0;
            if (since_reset <= STARTUP_CYCLES) begin
                assert (!txn_req && !out_valid)
                    else stop_with_error("bus request or output before the start-up wait ended");
            end
            if (out_valid) begin
                check_sample(out_count);
                out_count++;
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (cycles < timeout_limit) begin
            @(posedge clk);
            cycles++;
        end
        stop_with_error($sformatf("timeout: run did not finish within %0d clock cycles",
            timeout_limit));
    end

    initial begin
        reset_l = 1'b0;
        start   = 1'b0;
        $readmemh("verification/mag_testdata.txt", test_mem);
        timeout_limit = STARTUP_CYCLES + 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            timeout_limit += 12 * 12 + 12 * int'(test_mem[r * ROW_WIDTH])
                             + SETTLE_CYCLES + POLL_CYCLES;
        end
        repeat (10) @(posedge clk);
        #1;
        reset_l = 1'b1;
        start   = 1'b1;
        // last sample already under way, let it be the final one
        wait (out_count == NUM_RUNS - 1);
        @(posedge clk);
        #1;
        start = 1'b0;
        wait (out_count == NUM_RUNS);
        repeat (60) @(posedge clk);
        assert (measure_count == 2 + NUM_RUNS) else stop_with_error($sformatf(
            "Error at %0t ns: %0d measure commands, expected %0d",
            $time, measure_count, 2 + NUM_RUNS));
        assert (!txn_req) else stop_with_error("bus request still active after the last sample");
        if (UUT.u_assertions.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_with_error("handshake assertions failed during the run");
        end
    end

endmodule

//--- mag_compass.f
rtl/mag_compass_pkg.sv
rtl/mag_sequencer.sv
rtl/mag_bus_port.sv
rtl/mag_result.sv
rtl/mag_compass_top.sv
verification/mag_compass_assertions.sv
verification/mag_compass_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f mag_compass.f --top-module mag_compass_tb -o mag_compass_sim
sim_out=$(./obj_dir/mag_compass_sim 2>&1) || true
echo "$sim_out"
if echo "$sim_out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

//--- verification/mag_testdata.txt
// columns: not-ready polls, x lo, x hi, y lo, y hi, z lo, z hi
// rows: cal SET, cal RESET, then four run samples
// cal SET: x 0123, y ff80, z 7ff0
02 23 01 80 FF F0 7F
// cal RESET: x 0130, y ff01, z 8005
00 30 01 01 FF 05 80
// run 0
01 00 10 FF FF 00 00
// run 1, x at the negative limit
03 00 80 FF 7F 34 12
// run 2
00 5A A5 C3 3C 01 00
// run 3
02 FF 7F 00 80 AB CD
